// ==== Makefile ====
# Verilator flow for the shuttle robot navigation core
# override on the command line, e.g. make sim SEED=3 LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_shuttle_bot
SEED      ?= 0
LOG       ?= sim.log
FILELIST  ?= shuttle_bot.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(OBJ_DIR) -o $(TOP)

sim: $(OBJ_DIR)/$(TOP)
	./$(OBJ_DIR)/$(TOP) +verilator+seed+$(SEED) > $(LOG) 2>&1; cat $(LOG)
	@grep -q '\*\*\* PASSED \*\*\*' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== hw/direction_fsm.sv ====
`default_nettype none

module direction_fsm #(
    parameter logic [31:0] hold_cycles = robot_pkg::HOLD_CYCLES_DEFAULT
) (
    input  logic                               clk,
    input  logic                               rst_n,
    sense_if.fsm                               sense,
    input  logic [sensor_pkg::THRESH_BITS-1:0] threshold,
    input  logic                               estop,
    output robot_pkg::dir_t                    direction
);

    logic [sensor_pkg::DIST_BITS-1:0] dist_q;
    logic [sensor_pkg::FREQ_BITS-1:0] freq_q;
    logic                             estop_meta;
    logic                             estop_s;
    logic [31:0]                      hold_cnt;
    logic                             moving;
    logic                             hold_done;
    logic                             obstacle;
    logic                             tone_hit;
    robot_pkg::dir_t                  next_dir;

    assign moving    = (direction == robot_pkg::FORWARDS) ||
                       (direction == robot_pkg::BACKWARDS);
    assign hold_done = (hold_cnt >= hold_cycles);
    assign obstacle  = (dist_q < robot_pkg::TOO_CLOSE);
    assign tone_hit  = (freq_q > threshold);

    // latest sensor results, far and silent until the first reports
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dist_q <= '1;
            freq_q <= '0;
        end else begin
            if (sense.dist_valid) begin
                dist_q <= sense.distance;
            end
            if (sense.tone_valid) begin
                freq_q <= sense.tone_freq;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            estop_meta <= 1'b0;
            estop_s    <= 1'b0;
        end else begin
            estop_meta <= estop;
            estop_s    <= estop_meta;
        end
    end

    // minimum drive time, so an early echo cannot end a run
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hold_cnt <= '0;
        end else if (!moving) begin
            hold_cnt <= '0;
        end else if (!hold_done) begin
            hold_cnt <= hold_cnt + 1;
        end
    end

    always_comb begin
        next_dir = direction;
        case (direction)
            robot_pkg::IDLE_BASE: begin
                if (tone_hit) next_dir = robot_pkg::FORWARDS;
            end
            robot_pkg::FORWARDS: begin
                if (obstacle && hold_done) next_dir = robot_pkg::IDLE_TABLE;
            end
            robot_pkg::IDLE_TABLE: begin
                if (tone_hit) next_dir = robot_pkg::BACKWARDS;
            end
            robot_pkg::BACKWARDS: begin
                if (obstacle && hold_done) next_dir = robot_pkg::IDLE_BASE;
            end
            default: begin
                // STOP waits for the button to be released
                if (!estop_s) next_dir = robot_pkg::IDLE_BASE;
            end
        endcase
        // emergency stop overrides every state
        if (estop_s) begin
            next_dir = robot_pkg::STOP;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            direction <= robot_pkg::IDLE_BASE;
        end else begin
            direction <= next_dir;
        end
    end

endmodule

`default_nettype wire

// ==== hw/echo_ranger.sv ====
`default_nettype none

module echo_ranger #(
    parameter int unsigned ping_period   = sensor_pkg::PING_PERIOD_DEFAULT,
    parameter int unsigned cycles_per_cm = sensor_pkg::CYCLES_PER_CM,
    parameter int unsigned echo_timeout  = sensor_pkg::ECHO_TIMEOUT
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     echo,
    output logic     trig,
    sense_if.ranger  sense
);

    localparam logic [sensor_pkg::DIST_BITS-1:0] DIST_MAX = '1;

    logic                             echo_meta;
    logic                             echo_s;
    logic                             echo_q;
    logic [31:0]                      ping_cnt;
    logic [31:0]                      to_cnt;
    logic                             armed;
    logic [15:0]                      pre_cnt;
    logic [sensor_pkg::DIST_BITS-1:0] cm_cnt;
    logic                             echo_fall;
    logic                             arm;
    logic                             timed_out;

    assign echo_fall = echo_q & ~echo_s;
    // trig drops on the same edge that arms the measurement
    assign arm       = (ping_cnt == sensor_pkg::TRIG_CYCLES);
    assign timed_out = armed && (to_cnt == echo_timeout - 1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            echo_meta <= 1'b0;
            echo_s    <= 1'b0;
            echo_q    <= 1'b0;
        end else begin
            echo_meta <= echo;
            echo_s    <= echo_meta;
            echo_q    <= echo_s;
        end
    end

    // ping timing, trig is high for the first TRIG_CYCLES of each period
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ping_cnt <= '0;
            trig     <= 1'b0;
        end else begin
            trig     <= (ping_cnt < sensor_pkg::TRIG_CYCLES);
            ping_cnt <= (ping_cnt == ping_period - 1) ? '0 : ping_cnt + 1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            armed            <= 1'b0;
            to_cnt           <= '0;
            pre_cnt          <= '0;
            cm_cnt           <= '0;
            sense.distance   <= '0;
            sense.dist_valid <= 1'b0;
        end else begin
            sense.dist_valid <= 1'b0;
            if (arm) begin
                armed   <= 1'b1;
                to_cnt  <= '0;
                pre_cnt <= '0;
                cm_cnt  <= '0;
            end else if (armed && echo_fall) begin
                sense.distance   <= cm_cnt;
                sense.dist_valid <= 1'b1;
                armed            <= 1'b0;
            end else if (timed_out) begin
                // nothing came back, report out of range
                sense.distance   <= DIST_MAX;
                sense.dist_valid <= 1'b1;
                armed            <= 1'b0;
            end else begin
                if (armed) begin
                    to_cnt <= to_cnt + 1;
                end
                if (echo_s) begin
                    if (pre_cnt == 16'(cycles_per_cm - 1)) begin
                        pre_cnt <= '0;
                        if (cm_cnt != DIST_MAX) begin
                            cm_cnt <= cm_cnt + 1'b1;
                        end
                    end else begin
                        pre_cnt <= pre_cnt + 1'b1;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/motor_drive.sv ====
`default_nettype none

module motor_drive (
    input  logic                            clk,
    input  logic                            rst_n,
    input  robot_pkg::dir_t                 direction,
    input  logic [robot_pkg::PWM_BITS-1:0]  duty,
    output logic                            motor_fwd,
    output logic                            motor_rev,
    output logic                            enable
);

    logic [robot_pkg::PWM_BITS-1:0] pwm_cnt;
    logic                           pwm;
    logic                           go_fwd;
    logic                           go_rev;

    // duty of 0 keeps the pin low, each step adds one high cycle per period
    assign pwm    = (pwm_cnt < duty);
    assign go_fwd = (direction == robot_pkg::FORWARDS);
    assign go_rev = (direction == robot_pkg::BACKWARDS);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pwm_cnt <= '0;
        end else begin
            pwm_cnt <= pwm_cnt + 1'b1;
        end
    end

    // h-bridge pins, only one side ever switches
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            motor_fwd <= 1'b0;
            motor_rev <= 1'b0;
            enable    <= 1'b0;
        end else begin
            motor_fwd <= go_fwd & pwm;
            motor_rev <= go_rev & pwm;
            enable    <= go_fwd | go_rev;
        end
    end

endmodule

`default_nettype wire

// ==== hw/robot_pkg.sv ====
`default_nettype none

package robot_pkg;

    // shuttle direction, the encoding matches the motion states in order
    typedef enum logic [2:0] {
        IDLE_BASE  = 3'd0,
        FORWARDS   = 3'd1,
        IDLE_TABLE = 3'd2,
        BACKWARDS  = 3'd3,
        STOP       = 3'd4
    } dir_t;

    // obstacle distance in centimetres
    localparam logic [7:0] TOO_CLOSE = 8'd30;

    // minimum drive time, two seconds at 50 MHz
    localparam logic [31:0] HOLD_CYCLES_DEFAULT = 32'd100_000_000;

    // width of the duty input and of the pwm counter
    localparam int PWM_BITS = 8;

endpackage

`default_nettype wire

// ==== hw/sense_if.sv ====
`default_nettype none

interface sense_if;

    // ranger result, stable from dist_valid until the next pulse
    logic [sensor_pkg::DIST_BITS-1:0] distance;
    logic                             dist_valid;

    // tone result, stable from tone_valid until the next pulse
    logic [sensor_pkg::FREQ_BITS-1:0] tone_freq;
    logic                             tone_valid;

    modport ranger (output distance, output dist_valid);

    modport tone (output tone_freq, output tone_valid);

    modport fsm (
        input distance,
        input dist_valid,
        input tone_freq,
        input tone_valid
    );

endinterface

`default_nettype wire

// ==== hw/sensor_pkg.sv ====
`default_nettype none

package sensor_pkg;

    // result widths
    localparam int DIST_BITS   = 8;
    localparam int FREQ_BITS   = 10;
    localparam int THRESH_BITS = 5;

    // echo cycles per centimetre at 50 MHz
    localparam logic [15:0] CYCLES_PER_CM = 16'd2900;

    // trigger pulse length and ping spacing
    localparam int unsigned TRIG_CYCLES         = 500;
    localparam int unsigned PING_PERIOD_DEFAULT = 3_000_000;

    // tone measurement window
    localparam int unsigned TONE_WINDOW_DEFAULT = 5_000_000;

    // no echo after this many cycles reads as out of range
    localparam int unsigned ECHO_TIMEOUT = CYCLES_PER_CM * 256;

endpackage

`default_nettype wire

// ==== hw/shuttle_bot_top.sv ====
`default_nettype none

module shuttle_bot_top #(
    parameter logic [31:0] hold_cycles   = robot_pkg::HOLD_CYCLES_DEFAULT,
    parameter int unsigned ping_period   = sensor_pkg::PING_PERIOD_DEFAULT,
    parameter int unsigned tone_window   = sensor_pkg::TONE_WINDOW_DEFAULT,
    parameter int unsigned cycles_per_cm = sensor_pkg::CYCLES_PER_CM
) (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               echo,
    input  logic                               mic,
    input  logic                               estop,
    input  logic [sensor_pkg::THRESH_BITS-1:0] threshold,
    input  logic [robot_pkg::PWM_BITS-1:0]     duty,
    output logic                               trig,
    output logic                               motor_fwd,
    output logic                               motor_rev,
    output logic                               enable,
    output logic [sensor_pkg::DIST_BITS-1:0]   distance,
    output logic [sensor_pkg::FREQ_BITS-1:0]   tone_freq,
    output robot_pkg::dir_t                    direction
);

    sense_if sense ();

    assign distance  = sense.distance;
    assign tone_freq = sense.tone_freq;

    // timeout spans the full 8-bit range of centimetres
    echo_ranger #(
        .ping_period   (ping_period),
        .cycles_per_cm (cycles_per_cm),
        .echo_timeout  (cycles_per_cm * 256)
    ) u_echo_ranger (
        .clk   (clk),
        .rst_n (rst_n),
        .echo  (echo),
        .trig  (trig),
        .sense (sense)
    );

    tone_detector #(
        .tone_window (tone_window)
    ) u_tone_detector (
        .clk   (clk),
        .rst_n (rst_n),
        .mic   (mic),
        .sense (sense)
    );

    direction_fsm #(
        .hold_cycles (hold_cycles)
    ) u_direction_fsm (
        .clk       (clk),
        .rst_n     (rst_n),
        .sense     (sense),
        .threshold (threshold),
        .estop     (estop),
        .direction (direction)
    );

    motor_drive u_motor_drive (
        .clk       (clk),
        .rst_n     (rst_n),
        .direction (direction),
        .duty      (duty),
        .motor_fwd (motor_fwd),
        .motor_rev (motor_rev),
        .enable    (enable)
    );

endmodule

`default_nettype wire

// ==== hw/tone_detector.sv ====
`default_nettype none

module tone_detector #(
    parameter int unsigned tone_window = sensor_pkg::TONE_WINDOW_DEFAULT
) (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   mic,
    sense_if.tone  sense
);

    localparam logic [sensor_pkg::FREQ_BITS-1:0] FREQ_MAX = '1;

    logic                             mic_meta;
    logic                             mic_s;
    logic                             mic_q;
    logic                             mic_rise;
    logic [31:0]                      win_cnt;
    logic                             win_end;
    logic [sensor_pkg::FREQ_BITS-1:0] edge_cnt;
    logic [sensor_pkg::FREQ_BITS-1:0] edge_next;

    assign mic_rise = mic_s & ~mic_q;
    assign win_end  = (win_cnt == tone_window - 1);

    // saturating count including the edge seen this cycle
    assign edge_next = (mic_rise && edge_cnt != FREQ_MAX) ? edge_cnt + 1'b1 : edge_cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mic_meta <= 1'b0;
            mic_s    <= 1'b0;
            mic_q    <= 1'b0;
        end else begin
            mic_meta <= mic;
            mic_s    <= mic_meta;
            mic_q    <= mic_s;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            win_cnt <= '0;
        end else begin
            win_cnt <= win_end ? '0 : win_cnt + 1;
        end
    end

    // window end publishes the count and starts a fresh one
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            edge_cnt         <= '0;
            sense.tone_freq  <= '0;
            sense.tone_valid <= 1'b0;
        end else begin
            sense.tone_valid <= win_end;
            if (win_end) begin
                sense.tone_freq <= edge_next;
                edge_cnt        <= '0;
            end else begin
                edge_cnt <= edge_next;
            end
        end
    end

endmodule

`default_nettype wire

// ==== shuttle_bot.f ====
hw/robot_pkg.sv
hw/sensor_pkg.sv
hw/sense_if.sv
hw/echo_ranger.sv
hw/tone_detector.sv
hw/direction_fsm.sv
hw/motor_drive.sv
hw/shuttle_bot_top.sv
verif/shuttle_checker.sv
verif/tb_shuttle_bot.sv

// ==== verif/shuttle_checker.sv ====
`default_nettype none

module shuttle_checker #(
    parameter int ping_period   = 2000,
    parameter int tone_window   = 300,
    parameter int hold_cycles   = 200,
    parameter int cycles_per_cm = 4
) (
    input  wire logic            clk,
    input  wire logic            rst_n,
    input  wire logic            echo,
    input  wire logic            mic,
    input  wire logic            estop,
    input  wire logic [4:0]      threshold,
    input  wire logic [7:0]      duty,
    input  wire logic            trig,
    input  wire logic            motor_fwd,
    input  wire logic            motor_rev,
    input  wire logic            enable,
    input  wire logic [7:0]      distance,
    input  wire logic [9:0]      tone_freq,
    input  wire robot_pkg::dir_t direction,
    output int                   value_errs
);

    int              n;
    int              edges;
    int              cnt_now;
    int              exp_freq;
    int              m_hold;
    int              eff_dist;
    int              dist_lat;
    int              freq_lat;
    int              t;
    int              hi;
    int              due;
    int              exp_dist;
    int              ph;
    int              win_hi;
    logic            win_ok;
    logic            m1, m2, m3, e1, e2;
    logic            got_dist;
    logic            trig_q, echo_q, armed, dist_now;
    logic            exp_trig, m_fwd, m_rev, m_en;
    logic [7:0]      m_pwm;
    robot_pkg::dir_t m_dir;
    robot_pkg::dir_t nd;

    task automatic report(input string name, input int exp_v, input int act_v);
        $display("Fail at %0t: %s expected %0d got %0d", $time, name, exp_v, act_v);
        value_errs++;
    endtask

    // reference model reading the values present before each edge
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            n <= 0;
            edges <= 0;
            exp_freq <= 0;
            {m1, m2, m3, e1, e2} <= '0;
            m_dir <= robot_pkg::IDLE_BASE;
            m_hold <= 0;
            got_dist <= 1'b0;
            dist_lat <= 255;
            freq_lat <= 0;
            {m_fwd, m_rev, m_en, exp_trig} <= '0;
            m_pwm <= '0;
            {trig_q, echo_q, armed, dist_now} <= '0;
            t <= 0;
            hi <= 0;
            due <= 0;
            exp_dist <= 0;
        end else begin
            n <= n + 1;
            // rising edges of mic seen through the two synchroniser flops
            cnt_now = (m2 && !m3 && edges < 1023) ? edges + 1 : edges;
            if ((n + 1) % tone_window == 0) begin
                exp_freq <= cnt_now;
                edges <= 0;
            end else begin
                edges <= cnt_now;
            end
            m1 <= mic;
            m2 <= m1;
            m3 <= m2;
            // sensor results as the FSM latches them one cycle after they appear
            eff_dist = (got_dist || distance != 0) ? int'(distance) : 255;
            if (distance != 0) got_dist <= 1'b1;
            dist_lat <= eff_dist;
            freq_lat <= int'(tone_freq);
            nd = m_dir;
            case (m_dir)
                robot_pkg::IDLE_BASE:
                    if (freq_lat > int'(threshold)) nd = robot_pkg::FORWARDS;
                robot_pkg::FORWARDS:
                    if (dist_lat < 30 && m_hold >= hold_cycles) nd = robot_pkg::IDLE_TABLE;
                robot_pkg::IDLE_TABLE:
                    if (freq_lat > int'(threshold)) nd = robot_pkg::BACKWARDS;
                robot_pkg::BACKWARDS:
                    if (dist_lat < 30 && m_hold >= hold_cycles) nd = robot_pkg::IDLE_BASE;
                default:
                    nd = robot_pkg::IDLE_BASE;
            endcase
            if (e2) nd = robot_pkg::STOP;
            e1 <= estop;
            e2 <= e1;
            if (m_dir != robot_pkg::FORWARDS && m_dir != robot_pkg::BACKWARDS) begin
                m_hold <= 0;
            end else if (m_hold < hold_cycles) begin
                m_hold <= m_hold + 1;
            end
            m_dir <= nd;
            // pins follow the previous cycle's direction
            m_fwd <= (m_dir == robot_pkg::FORWARDS) && (m_pwm < duty);
            m_rev <= (m_dir == robot_pkg::BACKWARDS) && (m_pwm < duty);
            m_en <= (m_dir == robot_pkg::FORWARDS) || (m_dir == robot_pkg::BACKWARDS);
            m_pwm <= m_pwm + 8'd1;
            exp_trig <= (n % ping_period) < 500;
            // echo width measured from the end of trig
            dist_now <= 1'b0;
            if (due > 0) begin
                due <= due - 1;
                if (due == 1) dist_now <= 1'b1;
            end
            if (armed) begin
                t <= t + 1;
                if (echo) hi <= hi + 1;
                if (echo_q && !echo) begin
                    exp_dist <= (hi / cycles_per_cm > 255) ? 255 : hi / cycles_per_cm;
                    due <= 4;
                    armed <= 1'b0;
                end else if (t == cycles_per_cm * 256) begin
                    exp_dist <= 255;
                    due <= 4;
                    armed <= 1'b0;
                end
            end
            if (trig_q && !trig) begin
                armed <= 1'b1;
                t <= 0;
                hi <= 0;
            end
            trig_q <= trig;
            echo_q <= echo;
        end
    end

    // outputs are compared mid-cycle where they are stable
    always @(negedge clk) begin
        if (!rst_n) begin
            if (trig !== 1'b0) report("trig", 0, int'(trig));
            if ({motor_fwd, motor_rev, enable} !== 3'b000) begin
                report("motor pins", 0, int'({motor_fwd, motor_rev, enable}));
            end
            if (distance !== 8'd0) report("distance", 0, int'(distance));
            if (tone_freq !== 10'd0) report("tone_freq", 0, int'(tone_freq));
            if (direction !== robot_pkg::IDLE_BASE) report("direction", 0, int'(direction));
        end else begin
            if (trig !== exp_trig) report("trig", int'(exp_trig), int'(trig));
            if (direction !== m_dir) report("direction", int'(m_dir), int'(direction));
            if (motor_fwd !== m_fwd) report("motor_fwd", int'(m_fwd), int'(motor_fwd));
            if (motor_rev !== m_rev) report("motor_rev", int'(m_rev), int'(motor_rev));
            if (enable !== m_en) report("enable", int'(m_en), int'(enable));
            if (int'(tone_freq) != exp_freq) report("tone_freq", exp_freq, int'(tone_freq));
            if (dist_now && int'(distance) != exp_dist) begin
                report("distance", exp_dist, int'(distance));
            end
            // high count over one full pwm period while moving
            if (n >= 1) begin
                ph = (n - 1) % 256;
                if (ph == 0) begin
                    win_hi = 0;
                    win_ok = 1'b1;
                end
                win_hi = win_hi + int'(motor_fwd | motor_rev);
                win_ok = win_ok & enable;
                if (ph == 255 && win_ok && win_hi != int'(duty)) begin
                    report("pwm high count", int'(duty), win_hi);
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== verif/tb_shuttle_bot.sv ====
`default_nettype none

module tb_shuttle_bot;

    localparam int PING        = 2000;
    localparam int WIN         = 300;
    localparam int HOLD        = 200;
    localparam int CPC         = 4;
    localparam int RUN_WINDOWS = 36;
    localparam int LIMIT       = 40 * WIN + 2;

    logic            clk;
    logic            rst_n;
    logic            echo;
    logic            mic;
    logic            estop;
    logic [4:0]      threshold;
    logic [7:0]      duty;
    logic            trig;
    logic            motor_fwd;
    logic            motor_rev;
    logic            enable;
    logic [7:0]      distance;
    logic [9:0]      tone_freq;
    robot_pkg::dir_t direction;
    int              value_errs;
    int              cycles;
    logic [31:0]     rng_state;

    shuttle_bot_top #(
        .hold_cycles   (HOLD),
        .ping_period   (PING),
        .tone_window   (WIN),
        .cycles_per_cm (CPC)
    ) u_shuttle_bot_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .echo      (echo),
        .mic       (mic),
        .estop     (estop),
        .threshold (threshold),
        .duty      (duty),
        .trig      (trig),
        .motor_fwd (motor_fwd),
        .motor_rev (motor_rev),
        .enable    (enable),
        .distance  (distance),
        .tone_freq (tone_freq),
        .direction (direction)
    );

    shuttle_checker #(
        .ping_period   (PING),
        .tone_window   (WIN),
        .hold_cycles   (HOLD),
        .cycles_per_cm (CPC)
    ) u_checker (
        .clk (clk), .rst_n (rst_n), .echo (echo), .mic (mic), .estop (estop),
        .threshold (threshold), .duty (duty), .trig (trig),
        .motor_fwd (motor_fwd), .motor_rev (motor_rev), .enable (enable),
        .distance (distance), .tone_freq (tone_freq), .direction (direction),
        .value_errs (value_errs)
    );

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", LIMIT);
            $display("errors: %0d value, 1 timeout", value_errs);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // echo returns a random time after each trig, now and then never
    initial begin
        int d;
        int w;
        logic [31:0] r;
        wait (rst_n === 1'b1);
        forever begin
            @(negedge trig);
            r = next_rand();
            d = 1 + int'(r % 40);
            w = r[4] ? 20 + int'(next_rand() % 100) : 120 + int'(next_rand() % 780);
            repeat (d) @(posedge clk);
            #1;
            if (r[9:7] != 3'd0) begin
                echo = 1'b1;
                repeat (w) @(posedge clk);
                #1 echo = 1'b0;
            end
        end
    end

    initial begin
        int p;
        int est_at;
        int est_len;
        logic [31:0] r;
        clk = 1'b0;
        rst_n = 1'b0;
        cycles = 0;
        rng_state = 32'd18044;
        echo = 1'b0;
        mic = 1'b0;
        estop = 1'b0;
        threshold = 5'(6 + next_rand() % 10);
        duty = 8'(1 + next_rand() % 255);
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;
        for (int w = 0; w < RUN_WINDOWS; w++) begin
            r = next_rand();
            // a loud tone, a faint one below threshold, or silence
            case (r % 4)
                0: p = 8 + int'(next_rand() % 9);
                1: p = 80 + int'(next_rand() % 41);
                default: p = 0;
            endcase
            est_at = -1;
            est_len = 5 + int'(next_rand() % 40);
            if (w == 14 || w == 27) est_at = 20 + int'(next_rand() % 200);
            for (int k = 0; k < WIN; k++) begin
                @(posedge clk);
                #1;
                mic = (p > 0) ? ((k % p) < p / 2) : 1'b0;
                estop = (est_at >= 0 && k >= est_at && k < est_at + est_len);
            end
        end
        mic = 1'b0;
        estop = 1'b0;
        repeat (10) @(posedge clk);
        $display("errors: %0d value, 0 timeout", value_errs);
        if (value_errs == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
